// ==== bench/int_core_assert.sv ====
`timescale 1ns/100ps

module int_core_assert (
    input  logic                                clk,
    input  logic                                rst,
    input  core_arch_pkg::wb_t                  i_wb,
    input  core_arch_pkg::reg_idx_t             i_rs1,
    input  core_arch_pkg::reg_idx_t             i_rs2,
    input  logic [core_arch_pkg::xlen-1:0]      i_rs1_data,
    input  logic [core_arch_pkg::xlen-1:0]      i_rs2_data
);

    import core_arch_pkg::*;

    logic [xlen-1:0] shadow [0:31];            // Last clean write per register
    logic [31:0]     known;                    // Register has been written
    logic            clean_wr;
    logic            chk_rs1;
    logic            chk_rs2;
    logic [xlen-1:0] exp_rs1;
    logic [xlen-1:0] exp_rs2;

    // Excepting results and x0 targets never reach the shadow
    assign clean_wr = i_wb.valid && !i_wb.exception && (i_wb.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            known <= '0;
        end else if (clean_wr) begin
            known[i_wb.rd]  <= 1'b1;
            shadow[i_wb.rd] <= i_wb.result;
        end
    end

    always_comb begin
        chk_rs1 = known[i_rs1] || (clean_wr && (i_wb.rd == i_rs1));
        chk_rs2 = known[i_rs2] || (clean_wr && (i_wb.rd == i_rs2));
        exp_rs1 = (clean_wr && (i_wb.rd == i_rs1)) ? i_wb.result : shadow[i_rs1];
        exp_rs2 = (clean_wr && (i_wb.rd == i_rs2)) ? i_wb.result : shadow[i_rs2];
    end

    a_idle_after_reset: assert property (@(posedge clk) rst |=> !i_wb.valid)
        else $error("o_wb valid high in the cycle after reset");

    a_rs1_keeps: assert property (@(posedge clk) disable iff (rst)
        chk_rs1 |-> (i_rs1_data == exp_rs1))
        else $error("rs1 read differs from the last clean write");

    a_rs2_keeps: assert property (@(posedge clk) disable iff (rst)
        chk_rs2 |-> (i_rs2_data == exp_rs2))
        else $error("rs2 read differs from the last clean write");

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        ((i_rs1 == '0) |-> (i_rs1_data == '0)) and ((i_rs2 == '0) |-> (i_rs2_data == '0)))
        else $error("x0 read returned a nonzero value");

endmodule

// ==== bench/tb_int_core.sv ====
`timescale 1ns/100ps

module tb_int_core;

    import core_arch_pkg::*;
    import decode_pkg::*;

    localparam int wb_latency  = 2;            // Falling edges from issue to o_wb
    localparam int drain_limit = 20;

    logic            clk;
    logic            rst;
    logic            i_valid;
    logic [31:0]     i_instr;
    logic [alen-1:0] i_addr;
    wb_t             o_wb;

    logic [xlen-1:0] shadow [0:31];            // Architectural reference registers
    wb_t             exp_q [$];
    int unsigned     due_q [$];
    int unsigned     cyc;
    logic [alen-1:0] pc;
    string           cur_test;
    integer          seed;

    int_core dut (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_instr (i_instr),
        .i_addr  (i_addr),
        .o_wb    (o_wb)
    );

    bind int_core int_core_assert u_assert (
        .clk        (clk),
        .rst        (rst),
        .i_wb       (o_wb),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] enc_i(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                          logic [11:0] imm);
        return {imm, rs1, f3, rd, OP_OP_IMM, 2'b11};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                          reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_OP, 2'b11};
    endfunction

    function automatic logic [31:0] enc_u(opcode_e op, reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, op, 2'b11};
    endfunction

    // ISA-level result of one instruction against the shadow registers
    function automatic wb_t model(input logic [31:0] instr, input logic [alen-1:0] addr);
        wb_t             w;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm_u;
        logic [5:0]      sh;
        logic            is_reg;
        a      = shadow[instr[19:15]];
        is_reg = (instr[6:2] == OP_OP);
        b      = is_reg ? shadow[instr[24:20]] : {{(xlen-12){instr[31]}}, instr[31:20]};
        imm_u  = {{(xlen-32){instr[31]}}, instr[31:12], 12'h000};
        sh     = b[5:0];
        w.valid     = 1'b1;
        w.exception = 1'b0;
        w.rd        = instr[11:7];
        w.result    = '0;
        if (instr[1:0] != 2'b11) begin
            w.exception = 1'b1;
        end else begin
            case (instr[6:2])
                OP_LUI:   w.result = imm_u;
                OP_AUIPC: w.result = addr + imm_u;
                OP_OP_IMM, OP_OP: begin
                    case (instr[14:12])
                        3'd0: w.result = (is_reg && instr[30]) ? a - b : a + b;
                        3'd1: begin
                            w.result = a << sh;
                            if (!is_reg && instr[31:26] != '0) w.exception = 1'b1;
                        end
                        3'd2: w.result = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        3'd3: w.result = (a < b) ? 64'd1 : 64'd0;
                        3'd4: w.result = a ^ b;
                        3'd5: begin
                            if (instr[30]) begin
                                w.result = $signed(a) >>> sh;   // Sign fill
                            end else begin
                                w.result = a >> sh;
                            end
                            if (!is_reg && (instr[31] || instr[29:26] != '0)) begin
                                w.exception = 1'b1;
                            end
                        end
                        3'd6: w.result = a | b;
                        default: w.result = a & b;
                    endcase
                end
                default: w.exception = 1'b1;   // Not an integer opcode
            endcase
        end
        return w;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string what, input logic [xlen-1:0] exp,
                              input logic [xlen-1:0] act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: %s expected %h actual %h",
                                     cur_test, what, exp, act));
        end
    endtask

    // Excepting writebacks carry a defined result too
    task automatic check_wb(input wb_t exp, input wb_t act);
        if (act.valid !== exp.valid || act.exception !== exp.exception || act.rd !== exp.rd) begin
            report_failure($sformatf(
                "ERROR %s: expected valid=%b exc=%b rd=%0d actual valid=%b exc=%b rd=%0d",
                cur_test, exp.valid, exp.exception, exp.rd, act.valid, act.exception, act.rd));
        end
        check_word("result", exp.result, act.result);
    endtask

    // One falling edge, then match any writeback against the oldest issue
    task automatic tick();
        wb_t         exp;
        int unsigned due;
        @(negedge clk);
        cyc++;
        if ($isunknown(o_wb.valid)) begin
            report_failure($sformatf("o_wb valid is unknown in test %s", cur_test));
        end
        if (o_wb.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_failure($sformatf("Unexpected writeback in test %s", cur_test));
            end
            exp = exp_q.pop_front();
            due = due_q.pop_front();
            if (cyc != due) begin
                report_failure($sformatf("Writeback in test %s came at cycle %0d, not %0d",
                                         cur_test, cyc, due));
            end
            check_wb(exp, o_wb);
        end else if (due_q.size() != 0 && cyc >= due_q[0]) begin
            report_failure($sformatf("Writeback missing in test %s at cycle %0d", cur_test, cyc));
        end
    endtask

    task automatic issue(input logic [31:0] instr);
        wb_t w;
        tick();
        w       = model(instr, pc);
        i_valid = 1'b1;
        i_instr = instr;
        i_addr  = pc;
        exp_q.push_back(w);
        due_q.push_back(cyc + wb_latency);
        if (!w.exception && w.rd != '0) shadow[w.rd] = w.result;
        pc = pc + 4;
    endtask

    task automatic idle();
        tick();
        i_valid = 1'b0;
    endtask

    task automatic drain();
        for (int i = 0; exp_q.size() != 0; i++) begin
            if (i >= drain_limit) begin
                report_failure($sformatf("Test %s timed out waiting for writeback", cur_test));
            end
            idle();
        end
    endtask

    // Random 64-bit value built from LUI, ADDI, SLLI and XOR, x31 as scratch
    task automatic load_random(input reg_idx_t rd);
        logic [31:0] r;
        logic [31:0] s;
        r = $random(seed);
        s = $random(seed);
        issue(enc_u(OP_LUI, rd, r[31:12]));
        issue(enc_i(f3_add, rd, rd, r[11:0]));
        issue(enc_i(f3_sll, rd, rd, 12'd32));
        issue(enc_u(OP_LUI, 5'd31, s[31:12]));
        issue(enc_i(f3_add, 5'd31, 5'd31, s[11:0]));
        issue(enc_r(7'h00, f3_xor, rd, rd, 5'd31));
    endtask

    task automatic test_reset_idle();
        cur_test = "reset_idle";
        repeat (6) idle();
    endtask

    task automatic test_upper();
        logic [31:0] r;
        cur_test = "lui_auipc";
        for (int n = 0; n < 4; n++) begin
            r  = $random(seed);
            pc = {$random(seed), $random(seed)};
            issue(enc_u(OP_LUI, reg_idx_t'(5 + n), r[31:12]));
            issue(enc_u(OP_AUIPC, reg_idx_t'(12 + n), r[19:0]));
        end
        drain();
    endtask

    task automatic test_alu();
        logic [31:0] r;
        cur_test = "alu_random";
        for (int round = 0; round < 3; round++) begin
            load_random(5'd1);
            load_random(5'd2);
            r = $random(seed);
            issue(enc_i(f3_add, 5'd10, 5'd1, r[11:0]));
            issue(enc_i(f3_sll, 5'd11, 5'd1, {6'b000000, r[17:12]}));
            issue(enc_i(f3_slt, 5'd12, 5'd1, r[23:12]));
            issue(enc_i(f3_sltu, 5'd13, 5'd1, r[11:0]));
            issue(enc_i(f3_xor, 5'd14, 5'd1, r[31:20]));
            issue(enc_i(f3_sr, 5'd15, 5'd1, {6'b000000, r[23:18]}));
            issue(enc_i(f3_sr, 5'd16, 5'd1, {6'b010000, r[29:24]}));
            issue(enc_i(f3_or, 5'd17, 5'd1, r[19:8]));
            issue(enc_i(f3_and, 5'd18, 5'd1, r[27:16]));
            issue(enc_r(7'h00, f3_add, 5'd20, 5'd1, 5'd2));
            issue(enc_r(7'h20, f3_add, 5'd21, 5'd1, 5'd2));   // SUB
            issue(enc_r(7'h00, f3_sll, 5'd22, 5'd1, 5'd2));
            issue(enc_r(7'h00, f3_slt, 5'd23, 5'd1, 5'd2));
            issue(enc_r(7'h00, f3_sltu, 5'd24, 5'd2, 5'd1));
            issue(enc_r(7'h00, f3_xor, 5'd25, 5'd1, 5'd2));
            issue(enc_r(7'h00, f3_sr, 5'd26, 5'd1, 5'd2));
            issue(enc_r(7'h20, f3_sr, 5'd27, 5'd2, 5'd1));    // SRA
            issue(enc_r(7'h00, f3_or, 5'd28, 5'd1, 5'd2));
            issue(enc_r(7'h00, f3_and, 5'd29, 5'd1, 5'd2));
        end
        drain();
    endtask

    task automatic test_illegal();
        cur_test = "illegal";
        load_random(5'd5);
        issue({12'h000, 5'd0, 3'b000, 5'd5, 7'b0000011});     // LOAD opcode
        issue(enc_i(f3_sll, 5'd5, 5'd5, {6'b000001, 6'd3}));
        issue(enc_i(f3_sr, 5'd5, 5'd5, {6'b110000, 6'd1}));
        issue(enc_i(f3_sr, 5'd5, 5'd5, {6'b000010, 6'd1}));
        issue(enc_i(f3_add, 5'd6, 5'd5, 12'h000));            // Reads the old x5
        drain();
    endtask

    task automatic test_chains();
        cur_test = "dependent_chains";
        issue(enc_i(f3_add, 5'd1, 5'd0, 12'd7));
        issue(enc_r(7'h00, f3_add, 5'd2, 5'd1, 5'd1));
        issue(enc_r(7'h00, f3_add, 5'd3, 5'd2, 5'd1));
        issue(enc_r(7'h20, f3_add, 5'd4, 5'd1, 5'd3));
        issue(enc_r(7'h20, f3_sr, 5'd5, 5'd4, 5'd1));
        issue(enc_i(f3_sll, 5'd6, 5'd5, 12'd3));
        issue(enc_r(7'h00, f3_xor, 5'd7, 5'd6, 5'd5));
        issue(enc_i(f3_add, 5'd8, 5'd7, 12'hfff));
        drain();
    endtask

    task automatic test_x0();
        cur_test = "x0_writes";
        issue(enc_i(f3_add, 5'd0, 5'd0, 12'd5));
        issue(enc_i(f3_add, 5'd8, 5'd0, 12'd0));              // Distance 1 from x0
        issue(enc_u(OP_LUI, 5'd0, 20'habcde));
        idle();
        issue(enc_r(7'h00, f3_or, 5'd9, 5'd0, 5'd0));
        drain();
    endtask

    initial begin
        seed     = 32'h0bb0_6f7c;
        cyc      = 0;
        pc       = '0;
        cur_test = "reset";
        rst      = 1'b1;
        i_valid  = 1'b0;
        i_instr  = '0;
        i_addr   = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_reset_idle();
        test_upper();
        test_alu();
        test_illegal();
        test_chains();
        test_x0();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== hw/core_arch_pkg.sv ====
package core_arch_pkg;

    // Fixed RV64 widths
    localparam int xlen = 64;                  // Integer register width
    localparam int alen = 64;                  // Instruction address width
    localparam int shamt_w = $clog2(xlen);     // Shift amount bits

    typedef logic [4:0] reg_idx_t;             // Architectural register index

    // Result leaving the execute stage.
    // Also feeds the register file write port and distance-1 forwarding.
    typedef struct packed {
        logic            valid;                // Instruction retires this cycle
        logic            exception;            // Illegal op, nothing is written
        reg_idx_t        rd;                   // Destination register
        logic [xlen-1:0] result;               // Write data
    } wb_t;

endpackage

// ==== hw/decode_pkg.sv ====
package decode_pkg;

    import core_arch_pkg::*;

    // Major opcodes, instruction bits 6:2
    typedef enum logic [4:0] {
        OP_AUIPC  = 5'b00101,
        OP_OP_IMM = 5'b00100,
        OP_LUI    = 5'b01101,
        OP_OP     = 5'b01100
    } opcode_e;

    // funct3 codes shared by OP-IMM and OP
    localparam logic [2:0] f3_add  = 3'b000;   // ADD/SUB/ADDI
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;   // SRL/SRA and immediate forms
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [1:0] len_32  = 2'b11;    // Low bits of a 32-bit encoding

    // Instruction held in the decode register, operands already read
    typedef struct packed {
        logic            valid;                // Slot holds an instruction
        logic            is_int;               // One of the four integer opcodes
        logic [alen-1:0] addr;                 // Instruction address
        opcode_e         opcode;               // May carry a non-listed encoding
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        logic [2:0]      funct3;
        logic [6:0]      funct7;               // Bit 5 selects SUB and SRA
        logic [31:20]    i_imm;                // Raw I-type immediate
        logic [31:12]    u_imm;                // Raw U-type immediate
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
    } decoded_t;

    // True for the opcodes handled by the integer execute block
    function automatic logic is_int_op(input logic [31:0] instr);
        logic [4:0] op;
        op = instr[6:2];
        return (instr[1:0] == len_32) &&
               (op == OP_LUI || op == OP_AUIPC || op == OP_OP_IMM || op == OP_OP);
    endfunction

endpackage

// ==== hw/exec_int.sv ====
`timescale 1ns/100ps

module exec_int (
    input  logic                   clk,
    input  logic                   rst,
    input  decode_pkg::decoded_t   i_dec,
    output core_arch_pkg::wb_t     o_wb
);

    import core_arch_pkg::*;
    import decode_pkg::*;

    logic [xlen-1:0]    rs1;
    logic [xlen-1:0]    imm_i;                 // Sign-extended I immediate
    logic [xlen-1:0]    imm_u;                 // Sign-extended U immediate
    logic [xlen-1:0]    op_b;                  // Immediate or rs2
    logic               is_imm;
    logic               is_sub;
    logic               arith;                 // Instruction bit 30
    logic [shamt_w-1:0] shamt;
    logic [2*xlen-1:0]  shift_src;
    logic [xlen-1:0]    sum;
    logic               lt_s;
    logic               lt_u;
    logic [xlen-1:0]    result_d;
    logic               exc_d;

    assign rs1    = i_dec.rs1_data;
    assign imm_i  = {{(xlen-12){i_dec.i_imm[31]}}, i_dec.i_imm};
    assign imm_u  = {{(xlen-32){i_dec.u_imm[31]}}, i_dec.u_imm, 12'b0};
    assign is_imm = (i_dec.opcode == OP_OP_IMM);
    assign op_b   = is_imm ? imm_i : i_dec.rs2_data;
    assign arith  = i_dec.funct7[5];

    // SUB exists only in the register form
    assign is_sub = !is_imm && arith;
    assign sum    = is_sub ? rs1 - op_b : rs1 + op_b;

    // Immediate shift amount sits in the low bits of the immediate
    assign shamt  = op_b[shamt_w-1:0];

    // Upper half holds the sign fill for SRA/SRAI
    assign shift_src = {{xlen{arith & rs1[xlen-1]}}, rs1};

    assign lt_s = $signed(rs1) < $signed(op_b);
    assign lt_u = rs1 < op_b;                  // SLTIU compares the extended immediate

    always_comb begin
        result_d = '0;
        exc_d    = !i_dec.is_int;              // Unknown opcodes trap
        case (i_dec.opcode)
            OP_LUI: begin
                result_d = imm_u;
            end
            OP_AUIPC: begin
                result_d = xlen'(i_dec.addr) + imm_u;
            end
            OP_OP_IMM, OP_OP: begin
                case (i_dec.funct3)
                    f3_add: begin
                        result_d = sum;
                    end
                    f3_sll: begin
                        result_d = rs1 << shamt;
                        if (is_imm && i_dec.i_imm[31:26] != '0) begin
                            exc_d = 1'b1;      // Bad SLLI encoding
                        end
                    end
                    f3_slt: begin
                        result_d = {{(xlen-1){1'b0}}, lt_s};
                    end
                    f3_sltu: begin
                        result_d = {{(xlen-1){1'b0}}, lt_u};
                    end
                    f3_xor: begin
                        result_d = rs1 ^ op_b;
                    end
                    f3_sr: begin
                        result_d = xlen'(shift_src >> shamt);
                        if (is_imm && (i_dec.i_imm[31] || i_dec.i_imm[29:26] != '0)) begin
                            exc_d = 1'b1;      // Bad SRLI/SRAI encoding
                        end
                    end
                    f3_or: begin
                        result_d = rs1 | op_b;
                    end
                    f3_and: begin
                        result_d = rs1 & op_b;
                    end
                    default: begin
                        result_d = '0;
                    end
                endcase
            end
            default: begin
                result_d = '0;                 // Defined value on a trap
            end
        endcase
    end

    // Every decoded instruction retires, illegal ones flagged
    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= i_dec.valid;
        end
        o_wb.exception <= exc_d;
        o_wb.rd        <= i_dec.rd;
        o_wb.result    <= result_d;
    end

endmodule

// ==== hw/int_core.sv ====
`timescale 1ns/100ps

module int_core (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic [31:0]                         i_instr,
    input  logic [core_arch_pkg::alen-1:0]      i_addr,
    output core_arch_pkg::wb_t                  o_wb
);

    import core_arch_pkg::*;
    import decode_pkg::*;

    reg_idx_t        rs1;                      // Read indices from decode
    reg_idx_t        rs2;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    decoded_t        dec;

    int_regfile u_regfile (
        .clk        (clk),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_wb       (o_wb),                    // Writeback port
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    int_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_addr     (i_addr),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_wb       (o_wb),                    // Distance-1 bypass
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_dec      (dec)
    );

    exec_int u_exec (
        .clk        (clk),
        .rst        (rst),
        .i_dec      (dec),
        .o_wb       (o_wb)
    );

endmodule

// ==== hw/int_decoder.sv ====
`timescale 1ns/100ps

module int_decoder (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic [31:0]                         i_instr,
    input  logic [core_arch_pkg::alen-1:0]      i_addr,
    input  logic [core_arch_pkg::xlen-1:0]      i_rs1_data,
    input  logic [core_arch_pkg::xlen-1:0]      i_rs2_data,
    input  core_arch_pkg::wb_t                  i_wb,
    output core_arch_pkg::reg_idx_t             o_rs1,
    output core_arch_pkg::reg_idx_t             o_rs2,
    output decode_pkg::decoded_t                o_dec
);

    import core_arch_pkg::*;
    import decode_pkg::*;

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    decoded_t dec_d;
    decoded_t dec_q;
    logic     fwd_rs1_d;
    logic     fwd_rs2_d;
    logic     fwd_rs1_q;                       // rs1 depends on the older instruction
    logic     fwd_rs2_q;
    logic     fwd_ok;

    assign rs1_idx = i_instr[19:15];
    assign rs2_idx = i_instr[24:20];

    // Register file read ports see the raw fields
    assign o_rs1 = rs1_idx;
    assign o_rs2 = rs2_idx;

    // Field extraction
    always_comb begin
        dec_d.valid    = i_valid;
        dec_d.is_int   = is_int_op(i_instr);
        dec_d.addr     = i_addr;
        dec_d.opcode   = opcode_e'(i_instr[6:2]); // Unknown codes pass through
        dec_d.rd       = i_instr[11:7];
        dec_d.rs1      = rs1_idx;
        dec_d.rs2      = rs2_idx;
        dec_d.funct3   = i_instr[14:12];
        dec_d.funct7   = i_instr[31:25];
        dec_d.i_imm    = i_instr[31:20];
        dec_d.u_imm    = i_instr[31:12];
        dec_d.rs1_data = i_rs1_data;           // Includes distance-2 write-through
        dec_d.rs2_data = i_rs2_data;
    end

    // Distance-1 hazard: the instruction now in the decode register
    // has not produced its result yet, so remember which sources need it
    assign fwd_rs1_d = i_valid && dec_q.valid && (dec_q.rd != '0) && (dec_q.rd == rs1_idx);
    assign fwd_rs2_d = i_valid && dec_q.valid && (dec_q.rd != '0) && (dec_q.rd == rs2_idx);

    always_ff @(posedge clk) begin
        dec_q     <= dec_d;
        fwd_rs1_q <= fwd_rs1_d;
        fwd_rs2_q <= fwd_rs2_d;
        if (rst) begin
            dec_q.valid <= 1'b0;
            fwd_rs1_q   <= 1'b0;
            fwd_rs2_q   <= 1'b0;
        end
    end

    // An excepting producer wrote nothing, keep the file value
    assign fwd_ok = i_wb.valid && !i_wb.exception;

    always_comb begin
        o_dec = dec_q;
        if (fwd_rs1_q && fwd_ok) begin
            o_dec.rs1_data = i_wb.result;      // Bypass from execute
        end
        if (fwd_rs2_q && fwd_ok) begin
            o_dec.rs2_data = i_wb.result;
        end
    end

endmodule

// ==== hw/int_regfile.sv ====
`timescale 1ns/100ps

module int_regfile (
    input  logic                                clk,
    input  core_arch_pkg::reg_idx_t             i_rs1,
    input  core_arch_pkg::reg_idx_t             i_rs2,
    input  core_arch_pkg::wb_t                  i_wb,
    output logic [core_arch_pkg::xlen-1:0]      o_rs1_data,
    output logic [core_arch_pkg::xlen-1:0]      o_rs2_data
);

    import core_arch_pkg::*;

    logic [xlen-1:0] regs [1:31];              // x0 has no storage
    logic            wr_en;

    // Only clean, retiring results with a real destination are kept
    assign wr_en = i_wb.valid && !i_wb.exception && (i_wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[i_wb.rd] <= i_wb.result;
        end
    end

    // Shared read path, used by both ports
    function automatic logic [xlen-1:0] read_port(input reg_idx_t idx);
        logic [xlen-1:0] data;
        if (idx == '0) begin
            data = '0;                         // Hardwired zero
        end else if (wr_en && (i_wb.rd == idx)) begin
            data = i_wb.result;                // Write-through, distance 2
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1);
    end

    always_comb begin
        o_rs2_data = read_port(i_rs2);
    end

endmodule

// ==== src.f ====
hw/core_arch_pkg.sv
hw/decode_pkg.sv
hw/int_regfile.sv
hw/int_decoder.sv
hw/exec_int.sv
hw/int_core.sv
bench/int_core_assert.sv
bench/tb_int_core.sv
